// ==== all.f ====
+incdir+verilog
verilog/dac_ctrl_pkg.sv
verilog/dac_regs.sv
verilog/dac_update_seq.sv
verilog/dac_spi_master.sv
verilog/dac_ctrl_top.sv
dv/dac_spi_capture.sv
dv/dac_ctrl_tb.sv

// ==== dv/dac_ctrl_tb.sv ====
// Testbench for the DAC controller, drives the bus and code inputs and checks reads and frames.
// Run through all.f with dac_ctrl_tb as the top module.
`timescale 1ns/1ps
`include "dac_ctrl_consts.svh"

module dac_ctrl_tb;

    localparam int FRAME_CYC = 16 * `SPI_CLK_DIV + 3;
    localparam int MAX_CYC   = 40 * FRAME_CYC + 2000;

    logic                   clk;
    logic                   SET_DEFAULT_ON_RESET;
    dac_ctrl_pkg::bus_req_t bus;
    logic                   en_mmi_ctrl;
    logic [`DAC_CODE_W-1:0] code;
    logic                   code_stb;
    logic [`DAC_WORD_W-1:0] rdata;
    logic                   rd_valid;
    logic                   sclk;
    logic                   sync_n;
    logic                   sdin;
    logic                   updated_stb;
    logic [`DAC_WORD_W-1:0] frame;
    logic                   frame_stb;

    logic [15:0] shadow;
    logic [15:0] allowed[$];
    logic [15:0] last_frame;
    int          frame_cnt;
    int          upd_cnt;
    int          cycle;
    int          last_upd_cycle;
    int          last_acc_cycle;
    int          pass_cnt;
    int          fail_cnt;

    dac_ctrl_top dut_i (
        .clk (clk), .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET), .bus (bus),
        .en_mmi_ctrl (en_mmi_ctrl), .code (code), .code_stb (code_stb),
        .rdata (rdata), .rd_valid (rd_valid), .sclk (sclk), .sync_n (sync_n),
        .sdin (sdin), .updated_stb (updated_stb)
    );

    dac_spi_capture cap_i (
        .clk (clk), .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET), .sclk (sclk),
        .sync_n (sync_n), .sdin (sdin), .frame (frame), .frame_stb (frame_stb)
    );

    always #10 clk = ~clk;

    // expected DAC word after one bus write or one code strobe
    function automatic logic [15:0] dac_model(input logic [15:0] cur, input logic en,
                                              input bit is_code, input logic [15:0] data);
        if (is_code && !en) begin
            return {cur[15:14], data[7:0], cur[5:0]};
        end
        if (!is_code && en) begin
            return data;
        end
        return cur;
    endfunction

    task automatic check_val(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s got %h expected %h", $time, what, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    // one bus write (is_code 0) or one code strobe (is_code 1)
    task automatic apply_update(input bit is_code, input logic [15:0] data);
        @(posedge clk);
        #1;
        if (is_code) begin
            code     = data[7:0];
            code_stb = 1'b1;
        end else begin
            bus.wr_stb = 1'b1;
            bus.addr   = `ADDR_DAC_WORD;
            bus.wdata  = data;
        end
        if (is_code != en_mmi_ctrl) begin
            shadow = dac_model(shadow, en_mmi_ctrl, is_code, data);
            allowed.push_back(shadow);
            // the DUT takes the strobe at the next edge
            last_acc_cycle = cycle + 1;
        end
        @(posedge clk);
        #1;
        code_stb   = 1'b0;
        bus.wr_stb = 1'b0;
    endtask

    task automatic read_check(input logic [3:0] addr, input logic [15:0] exp, input string what);
        @(posedge clk);
        #1;
        bus.rd_stb = 1'b1;
        bus.addr   = addr;
        @(posedge clk);
        #1;
        bus.rd_stb = 1'b0;
        check_val(16'(rd_valid), 16'd1, {what, " rd_valid"});
        check_val(rdata, exp, what);
        @(posedge clk);
        #1;
        check_val(16'(rd_valid), 16'd0, {what, " rd_valid drop"});
    endtask

    // wait for updated_stb after the last accepted update and let the capture finish
    task automatic wait_settled();
        while (last_upd_cycle <= last_acc_cycle) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %s: %s", name, (fail_cnt == fails_before) ? "ok" : "errors");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // frame comparison and cycle limit
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        int hit;
        hit = -1;
        cycle++;
        if (updated_stb) begin
            last_upd_cycle = cycle;
            upd_cnt++;
        end
        if (frame_stb) begin
            frame_cnt++;
            last_frame = frame;
            foreach (allowed[i]) begin
                if (hit < 0 && allowed[i] === frame) begin
                    hit = i;
                end
            end
            if (hit < 0) begin
                $display("[FAIL] %0d ns: frame %h matches no recent DAC word", $time, frame);
                fail_cnt++;
            end else begin
                pass_cnt++;
                // this word and older ones can no longer appear
                repeat (hit + 1) void'(allowed.pop_front());
            end
        end
        if (cycle > MAX_CYC) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYC);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          fb;
        int          f0;
        int          u0;
        int          n;
        logic [15:0] w;
        clk = 1'b0;
        SET_DEFAULT_ON_RESET = 1'b1;
        bus = '0;
        en_mmi_ctrl = 1'b1;
        code = '0;
        code_stb = 1'b0;
        cycle = 0;
        last_upd_cycle = -1;
        last_acc_cycle = 0;
        frame_cnt = 0;
        upd_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        last_frame = '0;
        shadow = `DAC_DEFAULT_WORD;
        allowed.push_back(shadow);
        w = 16'($urandom(32'hf39f5010));
        repeat (10) @(posedge clk);
        #1;
        SET_DEFAULT_ON_RESET = 1'b0;

        fb = fail_cnt;
        wait_settled();
        check_val(16'(frame_cnt), 16'd1, "reset frame count");
        check_val(16'(upd_cnt), 16'd1, "reset updated_stb count");
        check_val(last_frame, `DAC_DEFAULT_WORD, "reset frame");
        report_test("reset_frame", fb);

        fb = fail_cnt;
        for (int e = 0; e < 2; e++) begin
            en_mmi_ctrl = e[0];
            read_check(`ADDR_VERSION, `MODULE_VERSION, "version read");
            read_check(`ADDR_DAC_WORD, shadow, "dac word read");
            read_check(`ADDR_EN_MMI, 16'(en_mmi_ctrl), "en_mmi read");
            repeat (3) read_check(4'($urandom_range(15, 3)), 16'd0, "unmapped read");
        end
        report_test("register_reads", fb);

        fb = fail_cnt;
        en_mmi_ctrl = 1'b1;
        for (int i = 0; i < 8; i++) begin
            f0 = frame_cnt;
            u0 = upd_cnt;
            w = 16'($urandom);
            apply_update(1'b0, w);
            wait_settled();
            check_val(16'(frame_cnt - f0), 16'd1, "bus write frame count");
            check_val(16'(upd_cnt - u0), 16'd1, "bus write updated_stb count");
            check_val(last_frame, w, "bus write frame");
            read_check(`ADDR_DAC_WORD, w, "bus write read-back");
        end
        report_test("bus_writes", fb);

        fb = fail_cnt;
        en_mmi_ctrl = 1'b0;
        for (int i = 0; i < 6; i++) begin
            apply_update(1'b1, 16'($urandom));
            wait_settled();
            check_val(last_frame, shadow, "code strobe frame");
        end
        // updates through the path that is switched off
        for (int e = 0; e < 2; e++) begin
            en_mmi_ctrl = e[0];
            f0 = frame_cnt;
            u0 = upd_cnt;
            repeat (4) apply_update(e[0], 16'($urandom));
            repeat (FRAME_CYC + 20) @(posedge clk);
            #1;
            check_val(16'(frame_cnt - f0), 16'd0, "ignored update frame count");
            check_val(16'(upd_cnt - u0), 16'd0, "ignored update updated_stb count");
            read_check(`ADDR_DAC_WORD, shadow, "ignored update read-back");
        end
        report_test("code_strobes", fb);

        fb = fail_cnt;
        for (int b = 0; b < 4; b++) begin
            f0 = frame_cnt;
            n = 5;
            en_mmi_ctrl = 1'($urandom);
            for (int i = 0; i < n; i++) begin
                apply_update(1'($urandom), 16'($urandom));
                repeat ($urandom_range(25, 5)) @(posedge clk);
            end
            wait_settled();
            check_val(last_frame, shadow, "burst final frame");
            if (frame_cnt - f0 > n + 1) begin
                $display("[FAIL] %0d ns: burst gave %0d frames for %0d updates",
                         $time, frame_cnt - f0, n);
                fail_cnt++;
            end else begin
                pass_cnt++;
            end
        end
        report_test("bursts", fb);

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/dac_spi_capture.sv ====
// DAC pin model for the testbench: rebuilds each 16-bit frame from sclk, sync_n and sdin.
// frame_stb pulses for one clk cycle once sync_n returns high after a full frame.
`timescale 1ns/1ps
`include "dac_ctrl_consts.svh"

module dac_spi_capture (
    input  logic                   clk,
    input  logic                   SET_DEFAULT_ON_RESET,
    input  logic                   sclk,
    input  logic                   sync_n,
    input  logic                   sdin,
    output logic [`DAC_WORD_W-1:0] frame,
    output logic                   frame_stb
);

    logic                   sclk_d;
    logic                   sync_n_d;
    logic [`DAC_WORD_W-1:0] shift_q;
    logic [4:0]             count_q;

    // pins move on clk edges, so edges are found against the previous sample
    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            sclk_d    <= 1'b1;
            sync_n_d  <= 1'b1;
            shift_q   <= '0;
            count_q   <= '0;
            frame     <= '0;
            frame_stb <= 1'b0;
        end else begin
            sclk_d    <= sclk;
            sync_n_d  <= sync_n;
            frame_stb <= 1'b0;
            // sdin still holds the bit just after sclk fell
            if (sclk_d && !sclk && !sync_n) begin
                shift_q <= {shift_q[`DAC_WORD_W-2:0], sdin};
                count_q <= count_q + 1'b1;
            end
            if (!sync_n_d && sync_n) begin
                if (count_q == 5'd`DAC_WORD_W) begin
                    frame     <= shift_q;
                    frame_stb <= 1'b1;
                end
                count_q <= '0;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the DAC controller testbench with Verilator, runs it and checks sim.log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f all.f \
    --top-module dac_ctrl_tb \
    -Mdir obj_dir \
    -o dac_ctrl_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/dac_ctrl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== verilog/dac_ctrl_consts.svh ====
// Widths, register map and timing constants for the AD5601-style DAC controller.
// Include wherever the package types or the register addresses are needed.
`ifndef DAC_CTRL_CONSTS_SVH
`define DAC_CTRL_CONSTS_SVH

// bus and DAC word geometry
`define DAC_WORD_W 16
`define DAC_CODE_W 8
`define DAC_PD_W 2
`define DAC_ADDR_W 4

// register map
`define ADDR_VERSION 4'd0
`define ADDR_DAC_WORD 4'd1
`define ADDR_EN_MMI 4'd2

// identification and power-up behaviour
`define MODULE_VERSION 16'h0001
// pd_mode 0, code 100, rsvd 0
`define DAC_DEFAULT_WORD 16'h1900
`define DAC_LOAD_DEFAULT 1'b1

// clk cycles per sclk period, even and at least 2
`define SPI_CLK_DIV 4

`endif

// ==== verilog/dac_ctrl_pkg.sv ====
// Shared types of the DAC controller: bus request, DAC word views and SPI frame request.
// Referenced by scoped name from the RTL and the testbench.
`include "dac_ctrl_consts.svh"

package dac_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus side
    ////////////////////////////////////////////////////////////////////////////

    // single-cycle strobes, wr_stb and rd_stb never high together
    typedef struct packed {
        logic                   wr_stb;
        logic                   rd_stb;
        logic [`DAC_ADDR_W-1:0] addr;
        logic [`DAC_WORD_W-1:0] wdata;
    } bus_req_t;

    ////////////////////////////////////////////////////////////////////////////
    // DAC word
    ////////////////////////////////////////////////////////////////////////////

    // AD5601 input shift register layout, bits 15:14 pd, 13:6 code, 5:0 don't care
    typedef struct packed {
        logic [`DAC_PD_W-1:0]                         pd_mode;
        logic [`DAC_CODE_W-1:0]                       code;
        logic [`DAC_WORD_W-`DAC_CODE_W-`DAC_PD_W-1:0] rsvd;
    } dac_fields_t;

    // raw view for the bus and the shifter, field view for the code merge
    typedef union packed {
        logic [`DAC_WORD_W-1:0] raw;
        dac_fields_t            fld;
    } dac_word_u;

    ////////////////////////////////////////////////////////////////////////////
    // frame request to the SPI serialiser
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      start;
        dac_word_u word;
    } spi_req_t;

endpackage

// ==== verilog/dac_ctrl_top.sv ====
// Top level of the DAC controller: register bank, frame sequencer and SPI serialiser.
// A change reaches done_stb 16*SPI_CLK_DIV+3 cycles later when the link is idle.
`timescale 1ns/1ps
`include "dac_ctrl_consts.svh"

module dac_ctrl_top (
    input  logic                   clk,
    input  logic                   SET_DEFAULT_ON_RESET,
    input  dac_ctrl_pkg::bus_req_t bus,
    input  logic                   en_mmi_ctrl,
    input  logic [`DAC_CODE_W-1:0] code,
    input  logic                   code_stb,
    output logic [`DAC_WORD_W-1:0] rdata,
    output logic                   rd_valid,
    output logic                   sclk,
    output logic                   sync_n,
    output logic                   sdin,
    output logic                   updated_stb
);

    dac_ctrl_pkg::dac_word_u dac_word;
    logic                    change_stb;
    dac_ctrl_pkg::spi_req_t  spi_req;
    logic                    busy;
    logic                    done_stb;

    dac_regs regs_i (
        .clk                  (clk),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .bus                  (bus),
        .en_mmi_ctrl          (en_mmi_ctrl),
        .code                 (code),
        .code_stb             (code_stb),
        .rdata                (rdata),
        .rd_valid             (rd_valid),
        .dac_word             (dac_word),
        .change_stb           (change_stb)
    );

    dac_update_seq seq_i (
        .clk                  (clk),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .dac_word             (dac_word),
        .change_stb           (change_stb),
        .busy                 (busy),
        .done_stb             (done_stb),
        .spi_req              (spi_req),
        .updated_stb          (updated_stb)
    );

    dac_spi_master spi_i (
        .clk                  (clk),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .spi_req              (spi_req),
        .busy                 (busy),
        .done_stb             (done_stb),
        .sclk                 (sclk),
        .sync_n               (sync_n),
        .sdin                 (sdin)
    );

endmodule

// ==== verilog/dac_regs.sv ====
// Memory-mapped register bank holding the DAC word; merges bus writes and direct code strobes.
// Each accepted update raises change_stb for one cycle along with the new word.
`timescale 1ns/1ps
`include "dac_ctrl_consts.svh"

module dac_regs (
    input  logic                        clk,
    input  logic                        SET_DEFAULT_ON_RESET,
    input  dac_ctrl_pkg::bus_req_t      bus,
    input  logic                        en_mmi_ctrl,
    input  logic [`DAC_CODE_W-1:0]      code,
    input  logic                        code_stb,
    output logic [`DAC_WORD_W-1:0]      rdata,
    output logic                        rd_valid,
    output dac_ctrl_pkg::dac_word_u     dac_word,
    output logic                        change_stb
);

    ////////////////////////////////////////////////////////////////////////////
    // update decode
    ////////////////////////////////////////////////////////////////////////////

    logic                    bus_wr_hit;
    logic                    code_wr_hit;
    dac_ctrl_pkg::dac_word_u word_q;
    logic                    change_q;
    logic [`DAC_WORD_W-1:0]  rdata_q;
    logic                    rd_valid_q;
    logic [`DAC_WORD_W-1:0]  rd_mux;

    // bus owns the whole word while en_mmi_ctrl is high
    assign bus_wr_hit  = bus.wr_stb && (bus.addr == `ADDR_DAC_WORD) && en_mmi_ctrl;
    // otherwise the direct strobe owns just the code field
    assign code_wr_hit = code_stb && !en_mmi_ctrl;

    ////////////////////////////////////////////////////////////////////////////
    // DAC word register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            word_q.raw <= `DAC_DEFAULT_WORD;
            change_q   <= 1'b0;
        end else begin
            change_q <= 1'b0;
            if (bus_wr_hit) begin
                word_q.raw <= bus.wdata;
                change_q   <= 1'b1;
            end else if (code_wr_hit) begin
                // pd_mode and rsvd are kept as they are
                word_q.fld.code <= code;
                change_q        <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (bus.addr)
            `ADDR_VERSION: begin
                rd_mux = `MODULE_VERSION;
            end
            `ADDR_DAC_WORD: begin
                rd_mux = word_q.raw;
            end
            `ADDR_EN_MMI: begin
                rd_mux = {{(`DAC_WORD_W-1){1'b0}}, en_mmi_ctrl};
            end
            default: begin
                // unmapped space reads as zero
                rd_mux = '0;
            end
        endcase
    end

    // data is valid one cycle after rd_stb
    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= bus.rd_stb;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.rd_stb) begin
            rdata_q <= rd_mux;
        end
    end

    assign dac_word   = word_q;
    assign change_stb = change_q;
    assign rdata      = rdata_q;
    assign rd_valid   = rd_valid_q;

endmodule

// ==== verilog/dac_spi_master.sv ====
// 16-bit SPI serialiser for the DAC, MSB first with active-low sync.
// sclk idles high and falls at mid-bit, where the DAC samples sdin.
`timescale 1ns/1ps
`include "dac_ctrl_consts.svh"

module dac_spi_master (
    input  logic                   clk,
    input  logic                   SET_DEFAULT_ON_RESET,
    input  dac_ctrl_pkg::spi_req_t spi_req,
    output logic                   busy,
    output logic                   done_stb,
    output logic                   sclk,
    output logic                   sync_n,
    output logic                   sdin
);

    localparam int SPI_HALF = `SPI_CLK_DIV / 2;
    localparam int PHASE_W  = $clog2(`SPI_CLK_DIV);
    localparam int BIT_W    = $clog2(`DAC_WORD_W);

    logic [PHASE_W-1:0]     phase_q;
    logic [BIT_W-1:0]       bit_q;
    logic [`DAC_WORD_W-1:0] shift_q;
    logic                   busy_q;
    logic                   done_q;
    logic                   sclk_q;
    logic                   sync_n_q;
    logic                   accept;
    logic                   bit_end;
    logic                   last_bit;

    assign accept   = spi_req.start && !busy_q;
    assign bit_end  = (phase_q == PHASE_W'(`SPI_CLK_DIV - 1));
    assign last_bit = (bit_q == BIT_W'(`DAC_WORD_W - 1));

    ////////////////////////////////////////////////////////////////////////////
    // divider, bit counter and pin control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            sclk_q   <= 1'b1;
            sync_n_q <= 1'b1;
            phase_q  <= '0;
            bit_q    <= '0;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                if (accept) begin
                    busy_q   <= 1'b1;
                    sync_n_q <= 1'b0;
                    sclk_q   <= 1'b1;
                    phase_q  <= '0;
                    bit_q    <= '0;
                end
            end else begin
                // falling edge in the middle of the bit
                if (phase_q == PHASE_W'(SPI_HALF - 1)) begin
                    sclk_q <= 1'b0;
                end
                if (bit_end) begin
                    sclk_q  <= 1'b1;
                    phase_q <= '0;
                    if (last_bit) begin
                        busy_q   <= 1'b0;
                        done_q   <= 1'b1;
                        sync_n_q <= 1'b1;
                    end else begin
                        bit_q <= bit_q + 1'b1;
                    end
                end else begin
                    phase_q <= phase_q + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // shift register
    ////////////////////////////////////////////////////////////////////////////

    // next bit appears together with the rising sclk edge
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= spi_req.word.raw;
        end else if (busy_q && bit_end) begin
            shift_q <= {shift_q[`DAC_WORD_W-2:0], 1'b0};
        end
    end

    assign busy     = busy_q;
    assign done_stb = done_q;
    assign sclk     = sclk_q;
    assign sync_n   = sync_n_q;
    assign sdin     = shift_q[`DAC_WORD_W-1];

endmodule

// ==== verilog/dac_update_seq.sv ====
// Frame sequencer between the register bank and the SPI serialiser.
// Changes seen during a frame fold into one pending flag and one follow-up frame.
`timescale 1ns/1ps
`include "dac_ctrl_consts.svh"

module dac_update_seq (
    input  logic                    clk,
    input  logic                    SET_DEFAULT_ON_RESET,
    input  dac_ctrl_pkg::dac_word_u dac_word,
    input  logic                    change_stb,
    input  logic                    busy,
    input  logic                    done_stb,
    output dac_ctrl_pkg::spi_req_t  spi_req,
    output logic                    updated_stb
);

    ////////////////////////////////////////////////////////////////////////////
    // state
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [1:0] ST_IDLE     = 2'd0;
    // start is on the wire, the serialiser has not taken it yet
    localparam logic [1:0] ST_STARTING = 2'd1;
    localparam logic [1:0] ST_WAITING  = 2'd2;

    logic [1:0]              state_q;
    logic                    pending_q;
    logic                    start_q;
    dac_ctrl_pkg::dac_word_u word_q;
    logic                    can_launch;
    logic                    launch;

    // a new frame may start from idle, or straight out of the done cycle
    assign can_launch = ((state_q == ST_IDLE) && !busy) ||
                        ((state_q == ST_WAITING) && done_stb);
    assign launch     = can_launch && (change_stb || pending_q);

    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            state_q   <= ST_IDLE;
            // arms the power-up frame of the default word
            pending_q <= `DAC_LOAD_DEFAULT;
            start_q   <= 1'b0;
        end else begin
            start_q <= launch;
            if (launch) begin
                pending_q <= 1'b0;
            end else if (change_stb) begin
                pending_q <= 1'b1;
            end

            case (state_q)
                ST_IDLE: begin
                    if (launch) begin
                        state_q <= ST_STARTING;
                    end
                end
                ST_STARTING: begin
                    state_q <= ST_WAITING;
                end
                ST_WAITING: begin
                    if (launch) begin
                        state_q <= ST_STARTING;
                    end else if (done_stb) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // frame word is sampled at launch, so it is always the newest value
    always_ff @(posedge clk) begin
        if (launch) begin
            word_q <= dac_word;
        end
    end

    assign spi_req.start = start_q;
    assign spi_req.word  = word_q;

    // a change landing in the done cycle counts as pending too
    assign updated_stb = done_stb && !pending_q && !change_stb;

endmodule
